// File: list.f
procPkg.sv
pipeIf.sv
fetch.sv
decode.sv
hazardUnit.sv
execute.sv
memory.sv
proc.sv
tbClock.sv
procTb.sv

// File: program.hex
// one 16-bit instruction per line, line order is the word address
// bits 15:12 opcode, 11:9 rd, 8:6 rs, 5:3 rt or 5:0 signed imm
5205 // 0  addi r1, r0, 5
5443 // 1  addi r2, r1, 3
1650 // 2  add  r3, r1, r2
28C8 // 3  sub  r4, r3, r1
4B10 // 4  xor  r5, r4, r2
3CD0 // 5  and  r6, r3, r2
7642 // 6  st   r3, 2(r1)
6E42 // 7  ld   r7, 2(r1)
13F8 // 8  add  r1, r7, r7
7300 // 9  st   r1, 0(r4)
8A02 // 10 beqz r5, +2 taken
F000 // 11 illegal, wrong path
5201 // 12 addi r1, r0, 1, wrong path
6500 // 13 ld   r2, 0(r4)
9401 // 14 bnez r2, +1 taken
5C07 // 15 addi r6, r0, 7, wrong path
8C03 // 16 beqz r6, +3 not taken
9A03 // 17 bnez r5, +3 not taken
5B7F // 18 addi r5, r5, -1
9A01 // 19 bnez r5, +1 taken
A000 // 20 illegal, wrong path
2770 // 21 sub  r3, r5, r6
10D8 // 22 add  r0, r3, r3
0000 // 23 halt

// File: procTb.sv
module procTb;
  import procPkg::*;

  localparam int ResetCycles = 16;
  localparam int WatchdogBase = 40;
  localparam int CyclesPerInstr = 8;
  localparam int MaxWrites = 64;

  logic    clk;
  logic    rstN;
  logic    err;
  logic    halted;
  logic    retireValid;
  regIdx_t retireReg;
  word_t   retireData;

  word_t   prog [MemWords];
  regIdx_t expReg [MaxWrites];
  word_t   expData [MaxWrites];
  int      expCount = 0;
  int      modelSteps = 0;
  int      beatIdx = 0;
  int      valueErrors = 0;
  int      otherErrors = 0;
  int      seed = 50845;

  tbClock clockGen (.clk);

  proc dut_i (.clk, .rstN, .err, .halted, .retireValid, .retireReg, .retireData);

  // sequential reference run, records every register write in order
  function automatic int runModel();
    word_t   regs [8];
    word_t   dmem [MemWords];
    word_t   ins;
    word_t   imm;
    word_t   val;
    regIdx_t rd;
    regIdx_t rs;
    regIdx_t rt;
    addr_t   pc;
    addr_t   ea;
    logic    writes;
    logic    done;
    int      steps;
    pc = '0;
    steps = 0;
    done = 1'b0;
    for (int i = 0; i < 8; i++) begin
      regs[i] = '0;
    end
    while (!done && steps < MemWords * 4) begin
      ins = prog[pc];
      rd = ins[11:9];
      rs = ins[8:6];
      rt = ins[5:3];
      imm = {{10{ins[5]}}, ins[5:0]};
      ea = regs[rs][7:0] + imm[7:0];
      writes = 1'b1;
      val = '0;
      steps++;
      pc = pc + 8'd1;
      case (ins[15:12])
        OpAdd:  val = regs[rs] + regs[rt];
        OpSub:  val = regs[rs] - regs[rt];
        OpAnd:  val = regs[rs] & regs[rt];
        OpXor:  val = regs[rs] ^ regs[rt];
        OpAddi: val = regs[rs] + imm;
        OpLd:   val = dmem[ea];
        OpSt: begin
          writes = 1'b0;
          dmem[ea] = regs[rd];
        end
        OpBeqz, OpBnez: begin
          writes = 1'b0;
          if ((regs[rd] == '0) == (ins[15:12] == OpBeqz)) begin
            pc = pc + imm[7:0];
          end
        end
        OpHalt: begin
          writes = 1'b0;
          done = 1'b1;
        end
        default: begin
          writes = 1'b0;
          done = 1'b1;
          otherErrors++;
          $display("model ran into an illegal opcode at address %0d", pc - 8'd1);
        end
      endcase
      if (writes && rd != '0 && expCount < MaxWrites) begin
        regs[rd] = val;
        expReg[expCount] = rd;
        expData[expCount] = val;
        expCount++;
      end
    end
    return steps;
  endfunction

  // counts retire beats like a flop would
  always @(posedge clk) begin
    if (!rstN) begin
      beatIdx <= 0;
    end else if (retireValid) begin
      beatIdx <= beatIdx + 1;
    end
  end

  retireRegOk: assert property (@(posedge clk) disable iff (!rstN)
    retireValid && beatIdx < expCount |-> retireReg == expReg[beatIdx])
    else begin
      valueErrors++;
      $display("FAIL retire[%0d].reg expected r%0d actual r%0d", $sampled(beatIdx),
               expReg[$sampled(beatIdx)], $sampled(retireReg));
    end

  retireDataOk: assert property (@(posedge clk) disable iff (!rstN)
    retireValid && beatIdx < expCount |-> retireData == expData[beatIdx])
    else begin
      valueErrors++;
      $display("FAIL retire[%0d].data expected %h actual %h", $sampled(beatIdx),
               expData[$sampled(beatIdx)], $sampled(retireData));
    end

  noExtraBeat: assert property (@(posedge clk) disable iff (!rstN)
    retireValid |-> beatIdx < expCount)
    else begin
      otherErrors++;
      $display("retire beat seen after the model's last register write");
    end

  noErr: assert property (@(posedge clk) disable iff (!rstN) !err)
    else begin
      otherErrors++;
      $display("err went high, an illegal instruction reached execute");
    end

  haltAfterBeats: assert property (@(posedge clk) disable iff (!rstN)
    halted |-> beatIdx == expCount)
    else begin
      valueErrors++;
      $display("FAIL haltOrder expected %0d actual %0d", expCount, $sampled(beatIdx));
    end

  quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
    halted |-> !retireValid)
    else begin
      otherErrors++;
      $display("retire beat seen while halted was high");
    end

  haltSticky: assert property (@(posedge clk) disable iff (!rstN)
    halted |=> halted)
    else begin
      otherErrors++;
      $display("halted dropped before reset");
    end

  // limit scales with the number of instructions the model executed
  initial begin
    wait (modelSteps > 0);
    repeat (ResetCycles + WatchdogBase + CyclesPerInstr * modelSteps) @(posedge clk);
    $display("timeout, HALT never reached write-back");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    $readmemh(ProgramFile, prog);
    modelSteps = runModel();
    repeat (ResetCycles) @(negedge clk);
    rstN = 1'b1;
    while (halted !== 1'b1) begin
      @(negedge clk);
    end
    // give a stray retire time to show up
    repeat (8) @(negedge clk);
    retireCount: assert (beatIdx == expCount)
      else begin
        valueErrors++;
        $display("FAIL retireCount expected %0d actual %0d", expCount, beatIdx);
      end
    $display("errors: %0d value, %0d other, %0d of %0d retire beats, %0d model steps",
             valueErrors, otherErrors, beatIdx, expCount, modelSteps);
    if (valueErrors + otherErrors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: tbClock.sv
module tbClock (
  output logic clk
);
  localparam int Period = 8;

  initial begin
    clk = 1'b0;
    forever begin
      #(Period / 2) clk = ~clk;
    end
  end

endmodule

// File: proc.sv
module proc (
  input  logic              clk,
  input  logic              rstN,
  output logic              err,
  output logic              halted,
  output logic              retireValid,
  output procPkg::regIdx_t  retireReg,
  output procPkg::word_t    retireData
);
  import procPkg::*;

  word_t      instr;
  addr_t      instrPc;
  logic       instrValid;
  logic       stall;
  logic       flush;
  addr_t      branchTarget;
  logic       haltSeen;
  logic [1:0] fwdRs;
  logic [1:0] fwdRt;
  logic       haltLatch;

  idExIf  idEx ();
  exMemIf exMem ();
  memWbIf memWb ();

  fetch fetchInst (.clk, .rstN, .stall, .flush, .branchTarget, .haltSeen,
                   .instr, .instrPc, .instrValid);

  decode decodeInst (.clk, .rstN, .instr, .instrPc, .instrValid, .stall, .flush,
                     .haltSeen, .idEx(idEx.driver), .memWb(memWb.reader));

  hazardUnit hazardInst (.instr, .idEx(idEx.reader), .exMem(exMem.reader),
                         .memWb(memWb.reader), .stall, .fwdRs, .fwdRt);

  execute executeInst (.clk, .rstN, .fwdRs, .fwdRt, .idEx(idEx.reader),
                       .exMem(exMem.driver), .memWb(memWb.reader), .flush,
                       .branchTarget, .err);

  memory memoryInst (.clk, .rstN, .exMem(exMem.reader), .memWb(memWb.driver));

  // sticky once HALT reaches write-back
  always_ff @(posedge clk) begin
    if (!rstN) begin
      haltLatch <= 1'b0;
    end else if (memWb.valid && memWb.isHalt) begin
      haltLatch <= 1'b1;
    end
  end

  assign halted = haltLatch || (memWb.valid && memWb.isHalt);

  assign retireValid = memWb.valid && memWb.regWrite;
  assign retireReg = memWb.rd;
  assign retireData = memWb.data;

endmodule

// File: memory.sv
module memory (
  input  logic    clk,
  input  logic    rstN,
  exMemIf.reader  exMem,
  memWbIf.driver  memWb
);
  import procPkg::*;

  word_t dmem [MemWords];
  addr_t addr;
  word_t loadData;
  word_t wbData;

  assign addr = exMem.result[7:0];
  assign loadData = dmem[addr];

  // write-back select
  assign wbData = exMem.isLoad ? loadData : exMem.result;

  always_ff @(posedge clk) begin
    if (exMem.valid && exMem.isStore) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWb.valid <= 1'b0;
    end else begin
      memWb.valid <= exMem.valid;
    end
  end

  always_ff @(posedge clk) begin
    memWb.rd <= exMem.rd;
    memWb.data <= wbData;
    memWb.regWrite <= exMem.regWrite;
    memWb.isHalt <= exMem.isHalt;
  end

  // load flag from decode and store flag from execute must not overlap
  loadStoreExcl: assert property (@(posedge clk) disable iff (!rstN)
    exMem.valid |-> !(exMem.isLoad && exMem.isStore));

endmodule

// File: execute.sv
module execute (
  input  logic           clk,
  input  logic           rstN,
  input  logic [1:0]     fwdRs,
  input  logic [1:0]     fwdRt,
  idExIf.reader          idEx,
  exMemIf.driver         exMem,
  memWbIf.reader         memWb,
  output logic           flush,
  output procPkg::addr_t branchTarget,
  output logic           err
);
  import procPkg::*;

  word_t opA;
  word_t opB;
  word_t result;
  logic  illegal;

  always_comb begin
    case (fwdRs)
      FwdEx:   opA = exMem.result;
      FwdWb:   opA = memWb.data;
      default: opA = idEx.rsVal;
    endcase
    case (fwdRt)
      FwdEx:   opB = exMem.result;
      FwdWb:   opB = memWb.data;
      default: opB = idEx.rtVal;
    endcase
  end

  // ADDI, LD and ST all use rs plus imm
  always_comb begin
    illegal = 1'b0;
    result = opA + idEx.imm;
    case (idEx.op)
      OpAdd: result = opA + opB;
      OpSub: result = opA - opB;
      OpAnd: result = opA & opB;
      OpXor: result = opA ^ opB;
      OpHalt, OpAddi, OpLd, OpSt, OpBeqz, OpBnez: illegal = 1'b0;
      default: illegal = 1'b1;
    endcase
  end

  // branch tests rd, which arrives on the rt path
  assign flush = idEx.valid &&
                 ((idEx.op == OpBeqz && opB == '0) || (idEx.op == OpBnez && opB != '0));
  assign branchTarget = idEx.pc + 8'd1 + idEx.imm[7:0];
  assign err = idEx.valid && illegal;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMem.valid <= 1'b0;
    end else begin
      exMem.valid <= idEx.valid;
    end
  end

  always_ff @(posedge clk) begin
    exMem.rd <= idEx.rd;
    exMem.result <= result;
    exMem.storeData <= opB;
    exMem.regWrite <= idEx.regWrite;
    exMem.isLoad <= idEx.isLoad;
    exMem.isStore <= (idEx.op == OpSt);
    exMem.isHalt <= (idEx.op == OpHalt);
  end

  // a taken branch leaves a bubble behind it in decode/execute
  flushBubble: assert property (@(posedge clk) disable iff (!rstN)
    flush |=> !idEx.valid);

endmodule

// File: hazardUnit.sv
module hazardUnit (
  input  procPkg::word_t instr,
  idExIf.reader          idEx,
  exMemIf.reader         exMem,
  memWbIf.reader         memWb,
  output logic           stall,
  output logic [1:0]     fwdRs,
  output logic [1:0]     fwdRt
);
  import procPkg::*;

  regIdx_t decRs;
  regIdx_t decRt;
  logic    exHit;
  logic    wbHit;

  assign decRs = srcRs(instr);
  assign decRt = srcRt(instr);

  // load in execute feeding the instruction in decode
  assign stall = idEx.valid && idEx.isLoad && (idEx.rd != '0) &&
                 (idEx.rd == decRs || idEx.rd == decRt);

  assign exHit = exMem.valid && exMem.regWrite;
  assign wbHit = memWb.valid && memWb.regWrite;

  // younger result wins
  assign fwdRs = (idEx.rs == '0) ? FwdReg :
                 (exHit && exMem.rd == idEx.rs) ? FwdEx :
                 (wbHit && memWb.rd == idEx.rs) ? FwdWb : FwdReg;
  assign fwdRt = (idEx.rt == '0) ? FwdReg :
                 (exHit && exMem.rd == idEx.rt) ? FwdEx :
                 (wbHit && memWb.rd == idEx.rt) ? FwdWb : FwdReg;

endmodule

// File: decode.sv
module decode (
  input  logic           clk,
  input  logic           rstN,
  input  procPkg::word_t instr,
  input  procPkg::addr_t instrPc,
  input  logic           instrValid,
  input  logic           stall,
  input  logic           flush,
  output logic           haltSeen,
  idExIf.driver          idEx,
  memWbIf.reader         memWb
);
  import procPkg::*;

  word_t   regs [8];
  opcode_t op;
  regIdx_t rd;
  regIdx_t rs;
  regIdx_t rt;
  word_t   rsVal;
  word_t   rtVal;
  logic    wbHit;
  logic    regWrite;
  logic    isLoad;

  assign op = opcode_t'(instr[15:12]);
  assign rd = instr[11:9];
  assign rs = srcRs(instr);
  assign rt = srcRt(instr);

  always_comb begin
    regWrite = 1'b0;
    case (op)
      OpAdd, OpSub, OpAnd, OpXor, OpAddi, OpLd: regWrite = (rd != '0);
      default: regWrite = 1'b0;
    endcase
  end

  assign isLoad = (op == OpLd);

  // HALT leaving decode on the correct path
  assign haltSeen = instrValid && (op == OpHalt) && !stall && !flush;

  // register file, write-through from write-back
  assign wbHit = memWb.valid && memWb.regWrite;
  assign rsVal = (rs == '0) ? '0 :
                 (wbHit && memWb.rd == rs) ? memWb.data : regs[rs];
  assign rtVal = (rt == '0) ? '0 :
                 (wbHit && memWb.rd == rt) ? memWb.data : regs[rt];

  always_ff @(posedge clk) begin
    if (wbHit && memWb.rd != '0) begin
      regs[memWb.rd] <= memWb.data;
    end
  end

  // bubble on stall or flush
  always_ff @(posedge clk) begin
    if (!rstN) begin
      idEx.valid <= 1'b0;
    end else begin
      idEx.valid <= instrValid && !stall && !flush;
    end
  end

  always_ff @(posedge clk) begin
    idEx.op <= op;
    idEx.rd <= rd;
    idEx.rs <= rs;
    idEx.rt <= rt;
    idEx.rsVal <= rsVal;
    idEx.rtVal <= rtVal;
    idEx.imm <= immExt(instr);
    idEx.pc <= instrPc;
    idEx.regWrite <= regWrite;
    idEx.isLoad <= isLoad;
  end

  // r0 writes are dropped here, so none may reach write-back
  noR0Write: assert property (@(posedge clk) disable iff (!rstN)
    memWb.valid && memWb.regWrite |-> memWb.rd != '0);

endmodule

// File: fetch.sv
module fetch (
  input  logic           clk,
  input  logic           rstN,
  input  logic           stall,
  input  logic           flush,
  input  procPkg::addr_t branchTarget,
  input  logic           haltSeen,
  output procPkg::word_t instr,
  output procPkg::addr_t instrPc,
  output logic           instrValid
);
  import procPkg::*;

  word_t rom [MemWords];
  addr_t pc;
  logic  frozen;
  logic  fetchOn;

  initial $readmemh(ProgramFile, rom);

  // the halt cycle itself already sends a bubble
  assign fetchOn = !stall && !frozen && !haltSeen;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
      frozen <= 1'b0;
      instrValid <= 1'b0;
    end else if (flush) begin
      pc <= branchTarget;
      instrValid <= 1'b0;
    end else begin
      if (haltSeen) begin
        frozen <= 1'b1;
      end
      if (fetchOn) begin
        pc <= pc + 8'd1;
      end
      // stall keeps the current word in place
      if (!stall) begin
        instrValid <= fetchOn;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetchOn && !flush) begin
      instr <= rom[pc];
      instrPc <= pc;
    end
  end

endmodule

// File: pipeIf.sv
// decode/execute register
interface idExIf;
  import procPkg::*;

  logic    valid;
  opcode_t op;
  regIdx_t rd;
  regIdx_t rs;
  regIdx_t rt;
  word_t   rsVal;
  word_t   rtVal;
  word_t   imm;
  addr_t   pc;
  logic    regWrite;
  logic    isLoad;

  modport driver (output valid, op, rd, rs, rt, rsVal, rtVal, imm, pc, regWrite, isLoad);
  modport reader (input valid, op, rd, rs, rt, rsVal, rtVal, imm, pc, regWrite, isLoad);
endinterface

// execute/memory register
interface exMemIf;
  import procPkg::*;

  logic    valid;
  regIdx_t rd;
  word_t   result;
  word_t   storeData;
  logic    regWrite;
  logic    isLoad;
  logic    isStore;
  logic    isHalt;

  modport driver (output valid, rd, result, storeData, regWrite, isLoad, isStore, isHalt);
  modport reader (input valid, rd, result, storeData, regWrite, isLoad, isStore, isHalt);
endinterface

// memory/write-back register
interface memWbIf;
  import procPkg::*;

  logic    valid;
  regIdx_t rd;
  word_t   data;
  logic    regWrite;
  logic    isHalt;

  modport driver (output valid, rd, data, regWrite, isHalt);
  modport reader (input valid, rd, data, regWrite, isHalt);
endinterface

// File: procPkg.sv
package procPkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  regIdx_t;
  typedef logic [7:0]  addr_t;

  // instruction bits 15:12, codes 10 to 15 are illegal
  typedef enum logic [3:0] {
    OpHalt = 4'd0,
    OpAdd  = 4'd1,
    OpSub  = 4'd2,
    OpAnd  = 4'd3,
    OpXor  = 4'd4,
    OpAddi = 4'd5,
    OpLd   = 4'd6,
    OpSt   = 4'd7,
    OpBeqz = 4'd8,
    OpBnez = 4'd9
  } opcode_t;

  localparam int MemWords = 256;
  localparam string ProgramFile = "program.hex";

  // operand forwarding selects
  localparam logic [1:0] FwdReg = 2'd0;
  localparam logic [1:0] FwdEx  = 2'd1;
  localparam logic [1:0] FwdWb  = 2'd2;

  function automatic word_t immExt(word_t instr);
    return {{10{instr[5]}}, instr[5:0]};
  endfunction

  // first read port, r0 when the opcode has no rs operand
  function automatic regIdx_t srcRs(word_t instr);
    case (opcode_t'(instr[15:12]))
      OpAdd, OpSub, OpAnd, OpXor, OpAddi, OpLd, OpSt: return instr[8:6];
      default: return '0;
    endcase
  endfunction

  // second read port, ST and the branches read rd here
  function automatic regIdx_t srcRt(word_t instr);
    case (opcode_t'(instr[15:12]))
      OpAdd, OpSub, OpAnd, OpXor: return instr[5:3];
      OpSt, OpBeqz, OpBnez: return instr[11:9];
      default: return '0;
    endcase
  endfunction

endpackage
